/* all.f */
+incdir+tests
hdl/cpu_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/cpu.sv
tests/tb_clock.sv
tests/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := tests/tb_isa_model.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(BUILD_DIR)

/* tests/tb_isa_model.svh */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

//////////////////////////////////////////////////
// instruction encoders
function automatic word_t enc_r(opcode_e op, int rd, int rs1, int rs2);
    return {op, 5'(rd), 5'(rs1), 5'(rs2), 12'd0};
endfunction

// immediate form, rs2 field overlaps the immediate
function automatic word_t enc_i(opcode_e op, int rd, int rs1, int imm);
    return {op, 5'(rd), 5'(rs1), 1'b0, 16'(imm)};
endfunction

function automatic word_t enc_b(opcode_e op, int imm);
    return {op, 10'd0, 1'b0, 16'(imm)};
endfunction

//////////////////////////////////////////////////
// architectural model
// walks the program in order and queues every visible write
function automatic void run_model();
    word_t   regs [NREG];
    logic    fl_n;
    logic    fl_z;
    word_t   pc;
    word_t   ins;
    word_t   imm;
    word_t   a;
    word_t   b;
    word_t   res;
    int      rd;
    int      steps;
    logic    alu;
    logic    take;
    opcode_e op;
    for (int i = 0; i < NREG; i++) begin
        regs[i] = '0;
    end
    fl_n  = 1'b0;
    fl_z  = 1'b0;
    pc    = RESET_PC;
    steps = 0;
    while (steps < MODEL_STEPS) begin
        ins = (pc < word_t'(MEM_WORDS)) ? imem[pc[7:0]] : '0;
        op  = opcode_e'(ins[31:27]);
        rd  = int'(ins[26:22]);
        a   = regs[ins[21:17]];
        b   = regs[ins[16:12]];
        imm = {{16{ins[15]}}, ins[15:0]};
        alu  = 1'b1;
        take = 1'b0;
        res  = '0;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = a + imm;
            default: alu = 1'b0;
        endcase
        case (op)
            OP_BEQ:  take = fl_z;
            OP_BNE:  take = ~fl_z;
            OP_BLT:  take = fl_n;
            OP_BGE:  take = ~fl_n;
            OP_JMP:  take = 1'b1;
            default: take = 1'b0;
        endcase
        // jump to itself ends the program
        if (op == OP_JMP && imm == '0) begin
            break;
        end
        if (alu) begin
            fl_n = res[31];
            fl_z = (res == '0);
            if (rd != 0) begin
                regs[rd] = res;
                exp_sel.push_back(reg_sel_t'(rd));
                exp_val.push_back(res);
            end
        end
        pc = take ? pc + imm : pc + 32'd1;
        steps++;
    end
endfunction

`endif

/* tests/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    localparam int MEM_WORDS   = 256;
    localparam int MODEL_STEPS = 1000;
    localparam int RST_CYCLES  = 4;
    localparam int TEST_CYCLES = 120;
    localparam int NUM_TESTS   = 6;
    // cycles a program runs before reset cuts in
    localparam int CUT_CYCLES  = 5;
    // twice the whole run, 20 ns per cycle
    localparam int WATCHDOG_NS = 2 * (NUM_TESTS * (TEST_CYCLES + RST_CYCLES + 2)
                                      + RST_CYCLES + CUT_CYCLES) * 20;

    logic     clk;
    logic     rst_n;
    word_t    imem_addr;
    word_t    imem_data;
    logic     wb_valid;
    reg_sel_t wb_sel;
    word_t    wb_data;

    word_t    imem [MEM_WORDS];
    int       prog_len;
    reg_sel_t exp_sel [$];
    word_t    exp_val [$];
    string    test_name;
    int       err_count;
    int       pass_count;
    int       fail_count;
    int       since_rst;
    int       rst_seen;

    `include "tb_isa_model.svh"

    tb_clock #(.PERIOD_NS(20)) u_clock (.clk(clk));

    cpu dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .wb_valid  (wb_valid),
        .wb_sel    (wb_sel),
        .wb_data   (wb_data)
    );

    // same cycle instruction port, nop outside the array
    always_comb begin
        imem_data = (imem_addr < word_t'(MEM_WORDS)) ? imem[imem_addr[7:0]] : '0;
    end

    //////////////////////////////////////////////////
    // monitor, sampled on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            if (rst_seen > 0) begin
                assert (wb_valid !== 1'b1) else begin
                    $display("%s: write reported while in reset", test_name);
                    err_count++;
                end
            end
            rst_seen++;
            since_rst = 0;
        end else begin
            rst_seen = 0;
            if (since_rst == 0) begin
                assert (imem_addr == RESET_PC) else begin
                    $display("ERR %s: expected imem_addr %h, got %h",
                             test_name, RESET_PC, imem_addr);
                    err_count++;
                end
            end
            // first write can only show up three cycles in
            if (since_rst < 3) begin
                assert (wb_valid !== 1'b1) else begin
                    $display("%s: write reported too early after reset", test_name);
                    err_count++;
                end
            end
            if (wb_valid === 1'b1) begin
                assert (exp_sel.size() != 0) else begin
                    $display("%s: unexpected write to r%0d", test_name, wb_sel);
                    err_count++;
                end
                if (exp_sel.size() != 0) begin
                    assert (wb_sel == exp_sel[0] && wb_data == exp_val[0]) else begin
                        $display("ERR %s: expected r%0d=%h, got r%0d=%h", test_name,
                                 exp_sel[0], exp_val[0], wb_sel, wb_data);
                        err_count++;
                    end
                    void'(exp_sel.pop_front());
                    void'(exp_val.pop_front());
                end
            end
            since_rst++;
        end
    end

    //////////////////////////////////////////////////
    // program helpers
    task automatic clear_prog();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
        end
        prog_len = 0;
        exp_sel.delete();
        exp_val.delete();
    endtask

    task automatic put(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // reset is already low here, the old program cannot run
    task automatic start_test(input string name);
        test_name = name;
        @(posedge clk);
        #1 rst_n = 1'b0;
        clear_prog();
    endtask

    // let the program start, then pull reset mid-flight
    task automatic run_then_reset(input int run_cycles);
        run_model();
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (run_cycles) @(posedge clk);
        #1 rst_n = 1'b0;
        // writes still in the pipe are lost to the reset
        exp_sel.delete();
        exp_val.delete();
    endtask

    task automatic finish_test();
        int errs_before;
        errs_before = err_count;
        run_model();
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (TEST_CYCLES) @(posedge clk);
        assert (exp_sel.size() == 0) else begin
            $display("%s: %0d expected writes were never reported", test_name,
                     exp_sel.size());
            err_count++;
        end
        if (err_count == errs_before) begin
            pass_count++;
            $display("test %s: pass", test_name);
        end else begin
            fail_count++;
            $display("test %s: fail", test_name);
        end
    endtask

    // flag setter, branch over two writes, landing write
    task automatic branch_case(input opcode_e op, input int val);
        put(enc_i(OP_ADDI, 1, 0, val));
        put(enc_b(op, 3));
        put(enc_i(OP_ADDI, 2, 0, 16'h11));
        put(enc_i(OP_ADDI, 3, 0, 16'h22));
        put(enc_i(OP_ADDI, 4, 0, val + 5));
    endtask

    //////////////////////////////////////////////////
    // test sequence
    initial begin
        rst_n      = 1'b0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        since_rst  = 0;
        rst_seen   = 0;
        void'($urandom(11));
        clear_prog();

        start_test("reset");
        for (int r = 1; r < 7; r++) begin
            put(enc_i(OP_ADDI, r, 0, 5 * r));
        end
        put(enc_b(OP_JMP, 0));
        // reset lands while writes are in flight
        run_then_reset(CUT_CYCLES);
        finish_test();

        start_test("alu");
        for (int r = 1; r < NREG; r++) begin
            put(enc_i(OP_ADDI, r, 0, int'($urandom & 32'hffff)));
        end
        put(enc_r(OP_ADD, 1 + int'($urandom % 31), 1 + int'($urandom % 31), 7));
        put(enc_r(OP_SUB, 1 + int'($urandom % 31), 1 + int'($urandom % 31), 9));
        put(enc_r(OP_AND, 1 + int'($urandom % 31), 1 + int'($urandom % 31), 12));
        put(enc_r(OP_OR, 1 + int'($urandom % 31), 1 + int'($urandom % 31), 20));
        put(enc_r(OP_XOR, 1 + int'($urandom % 31), 1 + int'($urandom % 31), 30));
        put(enc_b(OP_JMP, 0));
        finish_test();

        start_test("forwarding");
        put(enc_i(OP_ADDI, 1, 0, 7));
        put(enc_r(OP_ADD, 2, 1, 1));
        put(enc_i(OP_ADDI, 3, 0, -3));
        put(enc_i(OP_ADDI, 10, 0, 1));
        put(enc_r(OP_SUB, 4, 2, 3));
        put(enc_i(OP_ADDI, 5, 0, 100));
        put(enc_i(OP_ADDI, 11, 0, 2));
        put(enc_i(OP_ADDI, 12, 0, 3));
        put(enc_r(OP_XOR, 6, 5, 4));
        put(enc_r(OP_ADD, 7, 6, 6));
        put(enc_r(OP_AND, 8, 7, 6));
        put(enc_b(OP_JMP, 0));
        finish_test();

        start_test("r0");
        put(enc_i(OP_ADDI, 1, 0, 21));
        put(enc_i(OP_ADDI, 0, 0, 99));
        put(enc_r(OP_ADD, 0, 1, 1));
        put(enc_i(OP_ADDI, 5, 0, 4));
        put(enc_r(OP_ADD, 6, 0, 5));
        put(enc_r(OP_OR, 7, 0, 0));
        put(enc_b(OP_JMP, 0));
        finish_test();

        start_test("branches");
        branch_case(OP_BEQ, 0);
        branch_case(OP_BEQ, 1);
        branch_case(OP_BNE, 1);
        branch_case(OP_BNE, 0);
        branch_case(OP_BLT, -1);
        branch_case(OP_BLT, 1);
        branch_case(OP_BGE, 1);
        branch_case(OP_BGE, -1);
        put(enc_b(OP_JMP, 0));
        finish_test();

        start_test("jump_loop");
        put(enc_i(OP_ADDI, 1, 0, 5));
        put(enc_i(OP_ADDI, 2, 0, 0));
        put(enc_i(OP_ADDI, 2, 2, 3));
        put(enc_i(OP_ADDI, 1, 1, -1));
        put(enc_b(OP_BNE, -2));
        put(enc_b(OP_JMP, 3));
        put(enc_i(OP_ADDI, 9, 0, 1));
        put(enc_i(OP_ADDI, 9, 0, 2));
        put(enc_i(OP_ADDI, 3, 2, 0));
        put(enc_b(OP_JMP, 3));
        put(enc_i(OP_ADDI, 4, 0, 8));
        put(enc_b(OP_JMP, 3));
        put(enc_i(OP_ADDI, 5, 0, 9));
        put(enc_b(OP_JMP, -3));
        put(enc_b(OP_JMP, 0));
        finish_test();

        $display("%0d tests passed, %0d failed, %0d errors", pass_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

// free running testbench clock
module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period per toggle
    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* hdl/cpu.sv */
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    // instruction port
    input  word_t    imem_data,
    output word_t    imem_addr,
    // retired register writes
    output logic     wb_valid,
    output reg_sel_t wb_sel,
    output word_t    wb_data
);

    //////////////////////////////////////////////////
    // fetch/decode
    logic     fd_valid;
    word_t    fd_pc;
    word_t    fd_instr;

    // decode/execute
    logic     de_valid;
    word_t    de_pc;
    opcode_e  de_op;
    reg_sel_t de_rd;
    reg_sel_t de_rs1;
    reg_sel_t de_rs2;
    word_t    de_a;
    word_t    de_b;
    word_t    de_imm;

    // flush path back from execute
    logic     redirect;
    word_t    redirect_pc;

    //////////////////////////////////////////////////
    fetch_stage u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_data   (imem_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .fd_valid    (fd_valid),
        .fd_pc       (fd_pc),
        .fd_instr    (fd_instr)
    );

    // wb feeds back for register file write
    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .fd_valid (fd_valid),
        .fd_pc    (fd_pc),
        .fd_instr (fd_instr),
        .redirect (redirect),
        .wb_valid (wb_valid),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data),
        .de_valid (de_valid),
        .de_pc    (de_pc),
        .de_op    (de_op),
        .de_rd    (de_rd),
        .de_rs1   (de_rs1),
        .de_rs2   (de_rs2),
        .de_a     (de_a),
        .de_b     (de_b),
        .de_imm   (de_imm)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .de_valid    (de_valid),
        .de_pc       (de_pc),
        .de_op       (de_op),
        .de_rd       (de_rd),
        .de_rs1      (de_rs1),
        .de_rs2      (de_rs2),
        .de_a        (de_a),
        .de_b        (de_b),
        .de_imm      (de_imm),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_valid    (wb_valid),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data)
    );

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    // from decode/execute register
    input  logic     de_valid,
    input  word_t    de_pc,
    input  opcode_e  de_op,
    input  reg_sel_t de_rd,
    input  reg_sel_t de_rs1,
    input  reg_sel_t de_rs2,
    input  word_t    de_a,
    input  word_t    de_b,
    input  word_t    de_imm,
    // branch redirect, one cycle pulse
    output logic     redirect,
    output word_t    redirect_pc,
    // execute/writeback register
    output logic     wb_valid,
    output reg_sel_t wb_sel,
    output word_t    wb_data
);

    word_t  op_a;
    word_t  op_b;
    word_t  alu_res;
    logic   is_alu;
    logic   take;
    flags_t flags;
    flags_t flags_nxt;

    //////////////////////////////////////////////////
    // operand forwarding
    // only the wb slot needs a path, older results
    // come through the register file
    assign op_a = (wb_valid && (wb_sel == de_rs1)) ? wb_data : de_a;
    assign op_b = (wb_valid && (wb_sel == de_rs2)) ? wb_data : de_b;

    //////////////////////////////////////////////////
    // alu
    always_comb begin
        is_alu  = 1'b1;
        alu_res = '0;
        case (de_op)
            OP_ADD:  alu_res = op_a + op_b;
            OP_SUB:  alu_res = op_a - op_b;
            OP_AND:  alu_res = op_a & op_b;
            OP_OR:   alu_res = op_a | op_b;
            OP_XOR:  alu_res = op_a ^ op_b;
            OP_ADDI: alu_res = op_a + de_imm;
            default: is_alu = 1'b0;
        endcase
    end

    // n from sign bit, z from all-zero result
    always_comb begin
        flags_nxt         = '0;
        flags_nxt[FLAG_N] = alu_res[XLEN-1];
        flags_nxt[FLAG_Z] = (alu_res == '0);
    end

    // flag register, alu ops only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (de_valid && is_alu) begin
            flags <= flags_nxt;
        end
    end

    //////////////////////////////////////////////////
    // branch resolution
    // flags already hold the nearest older alu result
    always_comb begin
        case (de_op)
            OP_BEQ:  take = flags[FLAG_Z];
            OP_BNE:  take = ~flags[FLAG_Z];
            OP_BLT:  take = flags[FLAG_N];
            OP_BGE:  take = ~flags[FLAG_N];
            OP_JMP:  take = 1'b1;
            default: take = 1'b0;
        endcase
    end

    assign redirect    = de_valid & take;
    // target relative to the branch itself, in words
    assign redirect_pc = de_pc + de_imm;

    //////////////////////////////////////////////////
    // execute/writeback register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            // rd was zeroed in decode for non-writers
            wb_valid <= de_valid && (de_rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        wb_sel  <= de_rd;
        wb_data <= alu_res;
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    // from fetch/decode register
    input  logic     fd_valid,
    input  word_t    fd_pc,
    input  word_t    fd_instr,
    // flush from execute
    input  logic     redirect,
    // writeback into the register file
    input  logic     wb_valid,
    input  reg_sel_t wb_sel,
    input  word_t    wb_data,
    // decode/execute register
    output logic     de_valid,
    output word_t    de_pc,
    output opcode_e  de_op,
    output reg_sel_t de_rd,
    output reg_sel_t de_rs1,
    output reg_sel_t de_rs2,
    output word_t    de_a,
    output word_t    de_b,
    output word_t    de_imm
);

    opcode_e  raw_op;
    opcode_e  op;
    logic     writes_rd;
    reg_sel_t rd;
    reg_sel_t rs1;
    reg_sel_t rs2;
    word_t    imm;
    word_t    rs1_data;
    word_t    rs2_data;

    //////////////////////////////////////////////////
    // field extraction
    assign raw_op = opcode_e'(fd_instr[OPC_LSB +: OPCODE_W]);
    assign rs1    = fd_instr[RS1_LSB +: REG_SEL_W];
    assign rs2    = fd_instr[RS2_LSB +: REG_SEL_W];
    // sign extend low immediate
    assign imm    = {{(XLEN-IMM_W){fd_instr[IMM_W-1]}}, fd_instr[IMM_W-1:0]};

    // control decode
    always_comb begin
        op        = raw_op;
        writes_rd = 1'b0;
        case (raw_op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: writes_rd = 1'b1;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_JMP:         writes_rd = 1'b0;
            // unused codes fold into nop
            default: op = OP_NOP;
        endcase
    end

    // rd of zero means no write downstream
    assign rd = writes_rd ? fd_instr[RD_LSB +: REG_SEL_W] : '0;

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd1_sel  (rs1),
        .rd2_sel  (rs2),
        .wr_sel   (wb_sel),
        .wr_en    (wb_valid),
        .wr_data  (wb_data),
        .rd1_data (rs1_data),
        .rd2_data (rs2_data)
    );

    //////////////////////////////////////////////////
    // decode/execute pipeline register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_valid <= 1'b0;
        end else begin
            de_valid <= fd_valid & ~redirect;
        end
    end

    always_ff @(posedge clk) begin
        de_pc  <= fd_pc;
        de_op  <= op;
        de_rd  <= rd;
        de_rs1 <= rs1;
        de_rs2 <= rs2;
        de_a   <= rs1_data;
        de_b   <= rs2_data;
        de_imm <= imm;
    end

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // instruction port, answers in the same cycle
    input  word_t imem_data,
    // branch redirect from execute
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t imem_addr,
    // fetch/decode register
    output logic  fd_valid,
    output word_t fd_pc,
    output word_t fd_instr
);

    word_t pc;

    // word addressed, so pc drives the port directly
    assign imem_addr = pc;

    //////////////////////////////////////////////////
    // program counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            // branch target wins over sequential step
            pc <= redirect_pc;
        end else begin
            pc <= pc + word_t'(1);
        end
    end

    //////////////////////////////////////////////////
    // fetch/decode pipeline register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fd_valid <= 1'b0;
        end else begin
            // word fetched under a taken branch is wrong path
            fd_valid <= ~redirect;
        end
    end

    // payload only, qualified by fd_valid
    always_ff @(posedge clk) begin
        fd_pc    <= pc;
        fd_instr <= imem_data;
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [REG_SEL_W-1:0] rd1_sel,
    input  logic [REG_SEL_W-1:0] rd2_sel,
    input  logic [REG_SEL_W-1:0] wr_sel,
    input  logic                 wr_en,
    input  logic [XLEN-1:0]      wr_data,
    output logic [XLEN-1:0]      rd1_data,
    output logic [XLEN-1:0]      rd2_data
);

    logic [XLEN-1:0] regs [NREG];

    // write port, r0 is never stored
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_sel != '0)) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // read ports
    // same-cycle write passes straight through
    always_comb begin
        rd1_data = regs[rd1_sel];
        rd2_data = regs[rd2_sel];
        if (wr_en && (wr_sel == rd1_sel)) begin
            rd1_data = wr_data;
        end
        if (wr_en && (wr_sel == rd2_sel)) begin
            rd2_data = wr_data;
        end
        // r0 reads zero
        if (rd1_sel == '0) begin
            rd1_data = '0;
        end
        if (rd2_sel == '0) begin
            rd2_data = '0;
        end
    end

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    //////////////////////////////////////////////////
    // widths
    localparam int XLEN      = 32;
    localparam int NREG      = 32;
    localparam int REG_SEL_W = 5;
    localparam int OPCODE_W  = 5;
    localparam int IMM_W     = 16;

    //////////////////////////////////////////////////
    // instruction field positions (lsb of each field)
    localparam int OPC_LSB = 27;
    localparam int RD_LSB  = 22;
    localparam int RS1_LSB = 17;
    localparam int RS2_LSB = 12;

    // bit positions within the flag register
    localparam int FLAG_N = 1;
    localparam int FLAG_Z = 0;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;
    typedef logic [1:0]           flags_t;

    // opcode map, codes above OP_JMP decode as nop
    typedef enum logic [OPCODE_W-1:0] {
        OP_NOP  = 5'd0,
        OP_ADD  = 5'd1,
        OP_SUB  = 5'd2,
        OP_AND  = 5'd3,
        OP_OR   = 5'd4,
        OP_XOR  = 5'd5,
        OP_ADDI = 5'd6,
        OP_BEQ  = 5'd7,
        OP_BNE  = 5'd8,
        OP_BLT  = 5'd9,
        OP_BGE  = 5'd10,
        OP_JMP  = 5'd11
    } opcode_e;

endpackage
